// File: src.f
+incdir+include
verilog/hub_pkg.sv
verilog/reg_bus_if.sv
verilog/ebi_slave.sv
verilog/uart_regs.sv
verilog/uart_txrx.sv
verilog/gpio_bank.sv
verilog/ebi_periph_top.sv
bench/ebi_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module ebi_periph_tb -o ebi_sim
./obj_dir/ebi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: include/ebi_tb_tasks.svh
`ifndef EBI_TB_TASKS_SVH
`define EBI_TB_TASKS_SVH

localparam int          HOLD_CYC = 10;  // cycles an access stays on the bus
localparam int          IDLE_CYC = 4;   // gap between accesses
localparam logic [31:0] LCG_SEED = 32'd65;

logic [31:0] lcg_state = LCG_SEED;
int          err_cnt   = 0;
int          chk_cnt   = 0;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic [23:0] uart_addr(int ch, logic [1:0] sel);
  return (24'(ch + hub_pkg::BLK_UART0) << hub_pkg::OFS_W) | 24'(sel);
endfunction

function automatic logic [23:0] gpio_addr(int bank, logic kind);
  return (24'(hub_pkg::BLK_GPIO) << hub_pkg::OFS_W) | 24'(bank << 1) | 24'(kind);
endfunction

// expected pad value after a byte-lane write
function automatic logic [31:0] byte_merge(logic [31:0] old, logic [31:0] nw, logic [3:0] be);
  logic [31:0] res;
  res = old;
  for (int i = 0; i < 4; i++) begin
    if (be[i]) res[8*i +: 8] = nw[8*i +: 8];
  end
  return res;
endfunction

task automatic wait_cyc(int n);
  repeat (n) @(posedge clk);
endtask

////////////////////////////////////////////////////////////
// bus cycles on cs_n, oe_n, we_n, rd_wr, ebi_addr, ebi_wdata
////////////////////////////////////////////////////////////
task automatic bus_write(logic [23:0] addr, logic [31:0] data, logic [3:0] be = 4'hf);
  @(posedge clk);
  cs_n      <= 1'b0;
  rd_wr     <= 1'b0;
  we_n      <= ~be;
  ebi_addr  <= addr;
  ebi_wdata <= data;
  wait_cyc(HOLD_CYC);
  cs_n <= 1'b1;
  we_n <= 4'hf;
  wait_cyc(IDLE_CYC);
endtask

task automatic bus_read(logic [23:0] addr, output logic [31:0] data);
  @(posedge clk);
  cs_n     <= 1'b0;
  oe_n     <= 1'b0;
  rd_wr    <= 1'b1;
  ebi_addr <= addr;
  wait_cyc(HOLD_CYC);
  data = ebi_rdata;
  if (ebi_oe !== 1'b1) begin
    err_cnt++;
    $display("mismatch at %0t: data output enable low in read of %h", $time, addr);
  end
  cs_n  <= 1'b1;
  oe_n  <= 1'b1;
  rd_wr <= 1'b0;
  wait_cyc(IDLE_CYC);
endtask

task automatic check(string what, logic [31:0] got, logic [31:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic read_check(string what, logic [23:0] addr, logic [31:0] exp);
  logic [31:0] got;
  bus_read(addr, got);
  check(what, got, exp);
endtask

// each sr read here also clears that channel's overrun flag
task automatic poll_sr(int ch, int bit_pos, logic level, int tries);
  logic [31:0] sr;
  bit          done;
  done = 1'b0;
  for (int i = 0; i < tries && !done; i++) begin
    bus_read(uart_addr(ch, hub_pkg::UART_SR), sr);
    done = (sr[bit_pos] == level);
  end
  if (!done) begin
    err_cnt++;
    $display("uart %0d status bit %0d never reached %0b", ch, bit_pos, level);
  end
endtask

`endif

// File: bench/ebi_periph_tb.sv
module ebi_periph_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import hub_pkg::*;

  localparam int          NUM_UART  = 2;
  localparam int          NUM_GPIO  = 3;
  localparam int          MAX_CYC   = 40000;
  localparam logic [31:0] DIV       = 32'd3;  // bit period of 4 clocks
  localparam int          POLL_MAX  = 20;     // status reads before giving up

  logic                             clk;
  logic                             rst;
  logic                             cs_n, oe_n, rd_wr;
  logic [3:0]                       we_n;
  logic [ADDR_W-1:0]                ebi_addr;
  logic [DATA_W-1:0]                ebi_wdata, ebi_rdata;
  logic                             ebi_oe;
  logic [NUM_UART-1:0]              srx, stx, uart_int;
  logic [NUM_GPIO-1:0][DATA_W-1:0]  input_pad, output_pad;
  int                               cyc = 0;

  `include "ebi_tb_tasks.svh"

  // serial lines crossed between the two channels
  assign srx = {stx[0], stx[1]};

  ebi_periph_top #(
    .NUM_UART(NUM_UART),
    .NUM_GPIO(NUM_GPIO)
  ) ebi_periph_top_i (
    .clk(clk),
    .rst_i(rst),
    .cs_n_i(cs_n),
    .oe_n_i(oe_n),
    .we_n_i(we_n),
    .rd_wr_i(rd_wr),
    .ebi_addr_i(ebi_addr),
    .ebi_data_i(ebi_wdata),
    .srx_i(srx),
    .input_pad_i(input_pad),
    .ebi_data_o(ebi_rdata),
    .ebi_data_oe_o(ebi_oe),
    .stx_o(stx),
    .uart_int_o(uart_int),
    .output_pad_o(output_pad)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    while (cyc < MAX_CYC) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", MAX_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // uart helpers
  ////////////////////////////////////////////////////////////
  task automatic send_byte(int ch, logic [7:0] data);
    bus_write(uart_addr(ch, UART_TDR), {24'h0, data});
  endtask

  task automatic recv_check(int ch, logic [7:0] exp);
    poll_sr(ch, SR_RX_READY, 1'b1, POLL_MAX);
    read_check($sformatf("uart %0d rdr", ch), uart_addr(ch, UART_RDR), {24'h0, exp});
  endtask

  task automatic wait_int(int ch, logic level, int max_cyc);
    int n;
    n = 0;
    while (uart_int[ch] !== level && n < max_cyc) begin
      @(posedge clk);
      n++;
    end
    if (uart_int[ch] !== level) begin
      err_cnt++;
      $display("uart %0d interrupt stayed away from %0b for %0d cycles", ch, level, max_cyc);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset();
    check("data out after reset", ebi_rdata, 32'h0);
    check("data oe after reset", 32'(ebi_oe), 32'h0);
    check("stx idle", 32'(stx), 32'h3);
    check("interrupts after reset", 32'(uart_int), 32'h0);
    for (int b = 0; b < NUM_GPIO; b++) check("pads after reset", output_pad[b], 32'h0);
    for (int ch = 0; ch < NUM_UART; ch++) begin
      read_check("cr after reset", uart_addr(ch, UART_CR), 32'h0);
      read_check("sr after reset", uart_addr(ch, UART_SR), 32'h0);
    end
    read_check("unmapped block 5", 24'h000500, 32'h0);  // only blocks 0..2 exist
    read_check("unmapped block 15", 24'h000f03, 32'h0);
  endtask

  task automatic test_gpio();
    logic [31:0] exp_pad [NUM_GPIO];
    logic [31:0] val;
    logic [3:0]  be;
    for (int b = 0; b < NUM_GPIO; b++) begin
      val = lcg_next();
      bus_write(gpio_addr(b, GPIO_OUT), val);
      exp_pad[b] = val;
      check("pad after full write", output_pad[b], exp_pad[b]);
    end
    for (int r = 0; r < 2; r++) begin
      for (int b = 0; b < NUM_GPIO; b++) begin
        val = lcg_next();
        be  = lcg_next() >> 28;
        if (be == 4'h0) be = 4'h5;  // an access needs one lane at least
        bus_write(gpio_addr(b, GPIO_OUT), val, be);
        exp_pad[b] = byte_merge(exp_pad[b], val, be);
        check("pad after lane write", output_pad[b], exp_pad[b]);
        read_check("output reg readback", gpio_addr(b, GPIO_OUT), exp_pad[b]);
      end
    end
    // block 4 shares its low block bits with gpio bank 0
    read_check("unmapped block 4", 24'h000400, 32'h0);
    @(posedge clk);
    for (int b = 0; b < NUM_GPIO; b++) input_pad[b] <= lcg_next();
    @(posedge clk);
    for (int b = 0; b < NUM_GPIO; b++) begin
      read_check("input reg", gpio_addr(b, GPIO_IN), input_pad[b]);
    end
    read_check("bank 5 out", gpio_addr(5, GPIO_OUT), 32'h0);
    read_check("bank 5 in", gpio_addr(5, GPIO_IN), 32'h0);
  endtask

  task automatic test_loopback();
    logic [7:0] data;
    for (int ch = 0; ch < NUM_UART; ch++) begin
      bus_write(uart_addr(ch, UART_CR), DIV);
      read_check("cr divisor", uart_addr(ch, UART_CR), DIV);
    end
    for (int src = 0; src < NUM_UART; src++) begin
      for (int n = 0; n < 3; n++) begin
        data = lcg_next() >> 24;
        send_byte(src, data);
        recv_check(1 - src, data);
        read_check("sr after rdr read", uart_addr(1 - src, UART_SR), 32'h0);
      end
    end
  endtask

  task automatic test_busy();
    logic [7:0] first, second;
    first  = lcg_next() >> 24;
    second = ~first;
    send_byte(0, first);
    send_byte(0, second);  // lands while the first frame is on the line
    recv_check(1, first);
    poll_sr(0, SR_TX_BUSY, 1'b0, POLL_MAX);
    read_check("no second byte", uart_addr(1, UART_SR), 32'h0);
  endtask

  task automatic test_irq();
    logic [7:0] data;
    bus_write(uart_addr(1, UART_CR), DIV | (32'h1 << CR_RX_IE));
    check("rx irq idle", 32'(uart_int[1]), 32'h0);
    data = lcg_next() >> 24;
    send_byte(0, data);
    wait_int(1, 1'b1, 200);
    read_check("rdr under rx irq", uart_addr(1, UART_RDR), {24'h0, data});
    check("rx irq after rdr read", 32'(uart_int[1]), 32'h0);

    bus_write(uart_addr(0, UART_CR), DIV | (32'h1 << CR_TX_IE));
    check("tx irq while idle", 32'(uart_int[0]), 32'h1);
    data = lcg_next() >> 24;
    send_byte(0, data);
    check("tx irq while busy", 32'(uart_int[0]), 32'h0);
    wait_int(0, 1'b1, 200);
    recv_check(1, data);
    bus_write(uart_addr(0, UART_CR), DIV);
    bus_write(uart_addr(1, UART_CR), DIV);
    check("irqs off", 32'(uart_int), 32'h0);
  endtask

  task automatic test_overrun();
    logic [7:0] a, b;
    a = lcg_next() >> 24;
    b = lcg_next() >> 24;
    send_byte(0, a);
    poll_sr(0, SR_TX_BUSY, 1'b0, POLL_MAX);
    send_byte(0, b);
    poll_sr(0, SR_TX_BUSY, 1'b0, POLL_MAX);  // stop bit sampled before tx ends
    read_check("sr with overrun", uart_addr(1, UART_SR),
               (32'h1 << SR_RX_READY) | (32'h1 << SR_OVERRUN));
    read_check("rdr keeps second byte", uart_addr(1, UART_RDR), {24'h0, b});
    read_check("sr after clear", uart_addr(1, UART_SR), 32'h0);
  endtask

  initial begin
    rst       <= 1'b1;
    cs_n      <= 1'b1;
    oe_n      <= 1'b1;
    rd_wr     <= 1'b0;
    we_n      <= 4'hf;
    ebi_addr  <= '0;
    ebi_wdata <= '0;
    input_pad <= '0;
    wait_cyc(4);
    rst <= 1'b0;
    wait_cyc(2);

    test_reset();
    test_gpio();
    test_loopback();
    test_busy();
    test_irq();
    test_overrun();

    $display("checks %0d errors %0d cycles %0d", chk_cnt, err_cnt, cyc);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/ebi_periph_top.sv
module ebi_periph_top #(
  parameter int NUM_UART = 2,
  parameter int NUM_GPIO = 3
) (
  input  logic                                     clk,
  input  logic                                     rst_i,
  input  logic                                     cs_n_i,
  input  logic                                     oe_n_i,
  input  logic [3:0]                               we_n_i,
  input  logic                                     rd_wr_i,
  input  logic [hub_pkg::ADDR_W-1:0]               ebi_addr_i,
  input  logic [hub_pkg::DATA_W-1:0]               ebi_data_i,
  input  logic [NUM_UART-1:0]                      srx_i,
  input  logic [NUM_GPIO-1:0][hub_pkg::DATA_W-1:0] input_pad_i,
  output logic [hub_pkg::DATA_W-1:0]               ebi_data_o,
  output logic                                     ebi_data_oe_o,
  output logic [NUM_UART-1:0]                      stx_o,
  output logic [NUM_UART-1:0]                      uart_int_o,
  output logic [NUM_GPIO-1:0][hub_pkg::DATA_W-1:0] output_pad_o
);
  import hub_pkg::*;

  reg_bus_if bus [0:NUM_UART] ();  // one per block

  ebi_slave #(
    .NUM_UART(NUM_UART)
  ) ebi_slave_i (
    .clk(clk),
    .rst_i(rst_i),
    .cs_n_i(cs_n_i),
    .oe_n_i(oe_n_i),
    .we_n_i(we_n_i),
    .rd_wr_i(rd_wr_i),
    .ebi_addr_i(ebi_addr_i),
    .ebi_data_i(ebi_data_i),
    .ebi_data_o(ebi_data_o),
    .ebi_data_oe_o(ebi_data_oe_o),
    .bus(bus)
  );

  gpio_bank #(
    .NUM_GPIO(NUM_GPIO)
  ) gpio_bank_i (
    .clk(clk),
    .rst_i(rst_i),
    .input_pad_i(input_pad_i),
    .bus(bus[BLK_GPIO]),
    .output_pad_o(output_pad_o)
  );

  ////////////////////////////////////////////////////////////
  // uart channels
  ////////////////////////////////////////////////////////////
  for (genvar g = 0; g < NUM_UART; g++) begin : g_uart
    logic             tx_start, tx_busy, rx_valid;
    logic [7:0]       tx_byte, rx_byte;
    logic [DIV_W-1:0] divisor;

    uart_regs uart_regs_i (
      .clk(clk),
      .rst_i(rst_i),
      .rx_byte_i(rx_byte),
      .rx_valid_i(rx_valid),
      .tx_busy_i(tx_busy),
      .bus(bus[BLK_UART0 + g]),
      .tx_start_o(tx_start),
      .tx_byte_o(tx_byte),
      .divisor_o(divisor),
      .uart_int_o(uart_int_o[g])
    );

    uart_txrx uart_txrx_i (
      .clk(clk),
      .rst_i(rst_i),
      .divisor_i(divisor),
      .tx_start_i(tx_start),
      .tx_byte_i(tx_byte),
      .srx_i(srx_i[g]),
      .stx_o(stx_o[g]),
      .tx_busy_o(tx_busy),
      .rx_valid_o(rx_valid),
      .rx_byte_o(rx_byte)
    );
  end

endmodule

// File: verilog/gpio_bank.sv
module gpio_bank #(
  parameter int NUM_GPIO = 3
) (
  input  logic                                     clk,
  input  logic                                     rst_i,
  input  logic [NUM_GPIO-1:0][hub_pkg::DATA_W-1:0] input_pad_i,
  reg_bus_if.target                                bus,
  output logic [NUM_GPIO-1:0][hub_pkg::DATA_W-1:0] output_pad_o
);
  import hub_pkg::*;

  logic [NUM_GPIO-1:0][DATA_W-1:0] in_meta, in_q;
  logic [2:0]                      bank;
  logic                            kind;
  logic [DATA_W-1:0]               rd_word;

  assign bank = bus.addr.gpio.bank;
  assign kind = bus.addr.gpio.kind;

  // pads into the input registers
  always_ff @(posedge clk) begin
    if (rst_i) begin
      in_meta <= '0;
      in_q    <= '0;
    end else begin
      in_meta <= input_pad_i;
      in_q    <= in_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      output_pad_o <= '0;
    end else if (bus.wr_en && kind == GPIO_OUT) begin
      for (int b = 0; b < NUM_GPIO; b++) begin
        for (int l = 0; l < 4; l++) begin
          if (bank == 3'(b) && bus.byte_en[l]) output_pad_o[b][8*l +: 8] <= bus.wr_data[8*l +: 8];
        end
      end
    end
  end

  always_comb begin
    rd_word = '0;  // banks past NUM_GPIO read zero
    for (int b = 0; b < NUM_GPIO; b++) begin
      if (bank == 3'(b)) rd_word = (kind == GPIO_IN) ? in_q[b] : output_pad_o[b];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i)          bus.rd_data <= '0;
    else if (bus.rd_en) bus.rd_data <= rd_word;
  end

endmodule

// File: verilog/uart_txrx.sv
module uart_txrx (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [hub_pkg::DIV_W-1:0] divisor_i,
  input  logic                      tx_start_i,
  input  logic [7:0]                tx_byte_i,
  input  logic                      srx_i,
  output logic                      stx_o,
  output logic                      tx_busy_o,
  output logic                      rx_valid_o,
  output logic [7:0]                rx_byte_o
);
  import hub_pkg::*;

  logic [DIV_W-1:0] tx_tmr, rx_tmr;
  logic [3:0]       tx_cnt, rx_cnt;
  logic [9:0]       tx_sh;    // {stop, data, start}
  logic [1:0]       rx_sync;
  logic             rx_prev, rx_busy;
  logic [7:0]       rx_sh;

  ////////////////////////////////////////////////////////////
  // transmitter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_sh     <= '1;  // line idles high
      tx_cnt    <= '0;
      tx_tmr    <= '0;
      tx_busy_o <= 1'b0;
    end else if (!tx_busy_o) begin
      if (tx_start_i) begin
        tx_sh     <= {1'b1, tx_byte_i, 1'b0};
        tx_cnt    <= 4'd10;
        tx_tmr    <= divisor_i;
        tx_busy_o <= 1'b1;
      end
    end else if (tx_tmr != '0) begin
      tx_tmr <= tx_tmr - 1'b1;
    end else begin
      tx_tmr <= divisor_i;
      tx_sh  <= {1'b1, tx_sh[9:1]};  // lsb first
      tx_cnt <= tx_cnt - 1'b1;
      if (tx_cnt == 4'd1) tx_busy_o <= 1'b0;  // stop bit done
    end
  end

  assign stx_o = tx_sh[0];

  ////////////////////////////////////////////////////////////
  // receiver
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], srx_i};
      rx_prev <= rx_sync[1];
    end
  end

  // cnt 0 is the start bit, 1..8 data, 9 stop
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_busy    <= 1'b0;
      rx_cnt     <= '0;
      rx_tmr     <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!rx_busy) begin
        if (rx_prev && !rx_sync[1]) begin  // falling edge of start
          rx_busy <= 1'b1;
          rx_cnt  <= '0;
          rx_tmr  <= divisor_i >> 1;  // land on mid-bit
        end
      end else if (rx_tmr != '0) begin
        rx_tmr <= rx_tmr - 1'b1;
      end else begin
        rx_tmr <= divisor_i;
        rx_cnt <= rx_cnt + 1'b1;
        if (rx_cnt == 4'd0) begin
          if (rx_sync[1]) rx_busy <= 1'b0;  // glitch, not a start bit
        end else if (rx_cnt == 4'd9) begin
          rx_busy    <= 1'b0;
          rx_valid_o <= rx_sync[1];  // bad stop bit drops the byte
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_busy && rx_tmr == '0 && rx_cnt >= 4'd1 && rx_cnt <= 4'd8) begin
      rx_sh <= {rx_sync[1], rx_sh[7:1]};
    end
  end

  assign rx_byte_o = rx_sh;

endmodule

// File: verilog/uart_regs.sv
module uart_regs (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [7:0]                rx_byte_i,
  input  logic                      rx_valid_i,
  input  logic                      tx_busy_i,
  reg_bus_if.target                 bus,
  output logic                      tx_start_o,
  output logic [7:0]                tx_byte_o,
  output logic [hub_pkg::DIV_W-1:0] divisor_o,
  output logic                      uart_int_o
);
  import hub_pkg::*;

  logic [CR_TX_IE:0] cr_q;  // only the implemented bits
  logic [7:0]        rdr_q;
  logic              rx_ready_q, overrun_q;
  logic [1:0]        sel;
  logic              tdr_wr, rdr_rd, sr_rd;
  logic [DATA_W-1:0] sr_word, rd_word;

  assign sel    = bus.addr.uart.sel;
  assign tdr_wr = bus.wr_en && (sel == UART_TDR);
  assign rdr_rd = bus.rd_en && (sel == UART_RDR);
  assign sr_rd  = bus.rd_en && (sel == UART_SR);

  // control register, byte lanes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cr_q <= '0;
    end else if (bus.wr_en && sel == UART_CR) begin
      if (bus.byte_en[0]) cr_q[7:0] <= bus.wr_data[7:0];
      if (bus.byte_en[1]) cr_q[CR_DIV_MSB:8] <= bus.wr_data[CR_DIV_MSB:8];
      if (bus.byte_en[2]) cr_q[CR_TX_IE:CR_RX_IE] <= bus.wr_data[CR_TX_IE:CR_RX_IE];
    end
  end

  // transmit hand-off, dropped while the shifter is busy
  always_ff @(posedge clk) begin
    if (rst_i) tx_start_o <= 1'b0;
    else       tx_start_o <= tdr_wr && !tx_busy_i;
  end

  always_ff @(posedge clk) begin
    if (tdr_wr && !tx_busy_i) tx_byte_o <= bus.wr_data[7:0];
  end

  // receive side, a new byte wins over the read clear
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rdr_q      <= '0;
      rx_ready_q <= 1'b0;
      overrun_q  <= 1'b0;
    end else begin
      if (rx_valid_i) begin
        rdr_q      <= rx_byte_i;
        rx_ready_q <= 1'b1;
      end else if (rdr_rd) begin
        rx_ready_q <= 1'b0;
      end
      if (rx_valid_i && rx_ready_q && !rdr_rd) overrun_q <= 1'b1;
      else if (sr_rd)                          overrun_q <= 1'b0;
    end
  end

  always_comb begin
    sr_word              = '0;
    sr_word[SR_RX_READY] = rx_ready_q;
    sr_word[SR_TX_BUSY]  = tx_busy_i;
    sr_word[SR_OVERRUN]  = overrun_q;
    case (sel)
      UART_CR:  rd_word = DATA_W'(cr_q);
      UART_SR:  rd_word = sr_word;
      UART_RDR: rd_word = DATA_W'(rdr_q);
      default:  rd_word = '0;  // tdr is write only
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i)           bus.rd_data <= '0;
    else if (bus.rd_en)  bus.rd_data <= rd_word;
  end

  assign divisor_o  = cr_q[CR_DIV_MSB:0];
  assign uart_int_o = (rx_ready_q && cr_q[CR_RX_IE]) || (!tx_busy_i && cr_q[CR_TX_IE]);

endmodule

// File: verilog/ebi_slave.sv
module ebi_slave #(
  parameter int NUM_UART = 2
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       cs_n_i,
  input  logic                       oe_n_i,
  input  logic [3:0]                 we_n_i,
  input  logic                       rd_wr_i,
  input  logic [hub_pkg::ADDR_W-1:0] ebi_addr_i,
  input  logic [hub_pkg::DATA_W-1:0] ebi_data_i,
  output logic [hub_pkg::DATA_W-1:0] ebi_data_o,
  output logic                       ebi_data_oe_o,
  reg_bus_if.master                  bus [0:NUM_UART]
);
  import hub_pkg::*;

  localparam int NUM_BLK = NUM_UART + 1;  // gpio plus the uarts
  localparam logic [6:0] CTL_IDLE = 7'h7f;

  logic [6:0]         ctl_s1, ctl_s2;  // {cs_n, oe_n, rd_wr, we_n}
  ebi_addr_u          addr_s1, addr_s2, addr_q;
  logic [DATA_W-1:0]  data_s1, data_s2, wdata_q;
  logic [3:0]         be_q;
  logic               cs_n_s, oe_n_s, rd_wr_s;
  logic [3:0]         we_n_s;
  logic               wr_lvl, rd_lvl, acc_start, active;
  logic               wr_go, rd_go, rd_go_d;
  logic [NUM_BLK-1:0] blk_sel, hit_q;
  logic [DATA_W-1:0]  rd_data_a [NUM_BLK];
  logic [DATA_W-1:0]  rd_mux;

  ////////////////////////////////////////////////////////////
  // two stage sync of the asynchronous bus
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ctl_s1 <= CTL_IDLE;
      ctl_s2 <= CTL_IDLE;
    end else begin
      ctl_s1 <= {cs_n_i, oe_n_i, rd_wr_i, we_n_i};
      ctl_s2 <= ctl_s1;
    end
  end

  always_ff @(posedge clk) begin
    addr_s1 <= ebi_addr_i;
    addr_s2 <= addr_s1;
    data_s1 <= ebi_data_i;
    data_s2 <= data_s1;
  end

  assign {cs_n_s, oe_n_s, rd_wr_s, we_n_s} = ctl_s2;
  assign wr_lvl    = !cs_n_s && !rd_wr_s && (we_n_s != 4'hf);
  assign rd_lvl    = !cs_n_s && !oe_n_s && rd_wr_s;
  assign acc_start = (wr_lvl || rd_lvl) && !active; // first cycle of an access

  always_comb begin
    for (int b = 0; b < NUM_BLK; b++) begin
      blk_sel[b] = (addr_s2.uart.blk == BLK_W'(b));  // unmapped blocks match none
    end
  end

  ////////////////////////////////////////////////////////////
  // strobes, one pulse per access
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      active  <= 1'b0;
      wr_go   <= 1'b0;
      rd_go   <= 1'b0;
      rd_go_d <= 1'b0;
      hit_q   <= '0;
    end else begin
      active  <= wr_lvl || rd_lvl;
      wr_go   <= wr_lvl && !active;
      rd_go   <= rd_lvl && !active;
      rd_go_d <= rd_go;  // target data is registered by now
      if (acc_start) hit_q <= blk_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_start) begin
      addr_q  <= addr_s2;
      wdata_q <= data_s2;
      be_q    <= ~we_n_s;
    end
  end

  for (genvar b = 0; b < NUM_BLK; b++) begin : g_blk
    assign bus[b].addr    = addr_q;
    assign bus[b].wr_data = wdata_q;
    assign bus[b].byte_en = be_q;
    assign bus[b].wr_en   = wr_go && hit_q[b];
    assign bus[b].rd_en   = rd_go && hit_q[b];
    assign rd_data_a[b]   = bus[b].rd_data;
  end

  always_comb begin
    rd_mux = '0;
    for (int b = 0; b < NUM_BLK; b++) begin
      if (hit_q[b]) rd_mux = rd_data_a[b];
    end
  end

  // data drive holds until the master lets go of cs_n or oe_n
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ebi_data_oe_o <= 1'b0;
      ebi_data_o    <= '0;
    end else if (rd_go_d) begin
      ebi_data_oe_o <= 1'b1;
      ebi_data_o    <= rd_mux;
    end else if (!rd_lvl) begin
      ebi_data_oe_o <= 1'b0;
    end
  end

endmodule

// File: verilog/reg_bus_if.sv
interface reg_bus_if;
  import hub_pkg::*;

  ebi_addr_u         addr;
  logic [DATA_W-1:0] wr_data;
  logic [3:0]        byte_en;  // active high lanes
  logic              wr_en;    // one cycle pulse
  logic              rd_en;    // one cycle pulse
  logic [DATA_W-1:0] rd_data;  // valid the cycle after rd_en

  modport master (
    output addr, wr_data, byte_en, wr_en, rd_en,
    input  rd_data
  );

  modport target (
    input  addr, wr_data, byte_en, wr_en, rd_en,
    output rd_data
  );

endinterface

// File: verilog/hub_pkg.sv
package hub_pkg;

  ////////////////////////////////////////////////////////////
  // bus and address map
  ////////////////////////////////////////////////////////////
  localparam int DATA_W = 32;
  localparam int ADDR_W = 24;  // word address from the processor
  localparam int BLK_W  = 4;   // block field at address bits 11..8
  localparam int OFS_W  = 8;   // offset inside a block
  localparam int DIV_W  = 16;  // uart baud divisor

  localparam int BLK_GPIO  = 0;
  localparam int BLK_UART0 = 1; // uart n sits at block n+1

  // uart register select
  localparam logic [1:0] UART_CR  = 2'd0;
  localparam logic [1:0] UART_SR  = 2'd1;
  localparam logic [1:0] UART_TDR = 2'd2;
  localparam logic [1:0] UART_RDR = 2'd3;

  // gpio register kind
  localparam logic GPIO_OUT = 1'b0;
  localparam logic GPIO_IN  = 1'b1;

  // control register fields
  localparam int CR_DIV_MSB = DIV_W - 1; // bit period is divisor+1 clocks
  localparam int CR_RX_IE   = 16;
  localparam int CR_TX_IE   = 17;

  // status register fields
  localparam int SR_RX_READY = 0;
  localparam int SR_TX_BUSY  = 1;
  localparam int SR_OVERRUN  = 2;

  // one address word, decoded per block type
  typedef union packed {
    struct packed {
      logic [ADDR_W-OFS_W-BLK_W-1:0] upper;
      logic [BLK_W-1:0]              blk;
      logic [OFS_W-3:0]              rsvd;
      logic [1:0]                    sel;   // cr, sr, tdr, rdr
    } uart;
    struct packed {
      logic [ADDR_W-OFS_W-BLK_W-1:0] upper;
      logic [BLK_W-1:0]              blk;
      logic [OFS_W-5:0]              rsvd;
      logic [2:0]                    bank;
      logic                          kind;  // output or input register
    } gpio;
  } ebi_addr_u;

endpackage
